// File: src/wb_ic_settings.svh
// Wishbone crossbar settings
// Bus widths, port counts, address windows and SRAM depth
`ifndef WB_IC_SETTINGS_SVH
`define WB_IC_SETTINGS_SVH

`define WB_ADDR_WIDTH 32
`define WB_DATA_WIDTH 32

`define WB_N_MASTERS 3
`define WB_N_SLAVES 2

// Inclusive address windows of the two targets
`define WB_S0_BASE 32'h0000_0000
`define WB_S0_LIMIT 32'h0000_03FF
`define WB_S1_BASE 32'h0001_0000
`define WB_S1_LIMIT 32'h0001_03FF

`define WB_SRAM_WORDS 256

`endif

// File: src/wb_ic_pkg.sv
// Wishbone crossbar types
// Request and response bundles plus the target index
`include "wb_ic_settings.svh"

package wb_ic_pkg;

	// Master to target
	typedef struct packed {
		logic [`WB_ADDR_WIDTH-1:0]   adr;
		logic [`WB_DATA_WIDTH-1:0]   dat_w;
		logic [`WB_DATA_WIDTH/8-1:0] sel;
		logic                        we;
		logic                        cyc;
		logic                        stb;
	} wb_req_t;

	// Target to master
	typedef struct packed {
		logic [`WB_DATA_WIDTH-1:0] dat_r;
		logic                      ack;
		logic                      err;
	} wb_rsp_t;

	typedef logic [1:0] tgt_id_t;

	localparam tgt_id_t TGT_S0 = 2'd0;
	localparam tgt_id_t TGT_S1 = 2'd1;
	localparam tgt_id_t TGT_ERR = 2'd2;

endpackage

// File: src/wb_ic_master_port.sv
// Wishbone crossbar master port
// Decodes the address of a new cycle, latches the target and
// requests it until the steered ack or err comes back
`include "wb_ic_settings.svh"

module wb_ic_master_port
	import wb_ic_pkg::*;
(
	input  logic                     clk,
	input  logic                     rstn,
	input  wb_req_t                  req_i,
	input  logic                     done_i,
	output logic [`WB_N_SLAVES:0]    tgt_req_o,
	output tgt_id_t                  tgt_o,
	output logic                     busy_o
);

	typedef enum logic {ST_IDLE, ST_WAIT} state_t;

	state_t state;

	// Address outside both windows falls to the error target
	function automatic tgt_id_t decode(input logic [`WB_ADDR_WIDTH-1:0] adr);
		logic [`WB_ADDR_WIDTH-1:0] off0;
		logic [`WB_ADDR_WIDTH-1:0] off1;
		// Offsets wrap past the limit for addresses below the base
		off0 = adr - `WB_S0_BASE;
		off1 = adr - `WB_S1_BASE;
		if (off0 <= `WB_S0_LIMIT - `WB_S0_BASE) begin
			return TGT_S0;
		end
		if (off1 <= `WB_S1_LIMIT - `WB_S1_BASE) begin
			return TGT_S1;
		end
		return TGT_ERR;
	endfunction

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= ST_IDLE;
			tgt_o <= TGT_S0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req_i.cyc && req_i.stb) begin
						state <= ST_WAIT;
						tgt_o <= decode(req_i.adr);
					end
				end
				ST_WAIT: begin
					if (done_i) begin
						state <= ST_IDLE;
						tgt_o <= TGT_S0;
					end
				end
			endcase
		end
	end

	assign busy_o = (state == ST_WAIT);

	always_comb begin
		tgt_req_o = '0;
		if (busy_o) begin
			tgt_req_o[tgt_o] = 1'b1;
		end
	end

endmodule

// File: src/wb_ic_arbiter.sv
// Round-robin arbiter for one crossbar target
// Grant is registered and held until the granted request drops
`include "wb_ic_settings.svh"

module wb_ic_arbiter (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic [`WB_N_MASTERS-1:0] req_i,
	output logic                     gnt_o,
	output logic [1:0]               gnt_id_o
);

	localparam int N = `WB_N_MASTERS;

	logic [N-1:0] gnt_oh;
	logic [N-1:0] last_gnt;
	logic [N-1:0] above_last;
	logic [N-1:0] pick;

	// Returns the lowest set bit as a one-hot vector
	function automatic logic [N-1:0] lowest(input logic [N-1:0] v);
		logic [N-1:0] r;
		r = '0;
		for (int i = N - 1; i >= 0; i--) begin
			if (v[i]) begin
				r = '0;
				r[i] = 1'b1;
			end
		end
		return r;
	endfunction

	function automatic logic [1:0] oh2id(input logic [N-1:0] oh);
		logic [1:0] id;
		id = '0;
		for (int i = 0; i < N; i++) begin
			if (oh[i]) begin
				id = 2'(i);
			end
		end
		return id;
	endfunction

	// Bits strictly above the last granted requester
	always_comb begin
		logic seen;
		seen = 1'b0;
		for (int i = 0; i < N; i++) begin
			above_last[i] = seen;
			seen = seen | last_gnt[i];
		end
	end

	always_comb begin
		if (|(req_i & above_last)) begin
			pick = lowest(req_i & above_last);
		end else begin
			pick = lowest(req_i);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_oh <= '0;
			last_gnt <= '0;
			gnt_id_o <= '0;
		end else if (!gnt_o) begin
			if (|pick) begin
				gnt_oh <= pick;
				last_gnt <= pick;
				gnt_id_o <= oh2id(pick);
			end
		end else if ((gnt_oh & req_i) == '0) begin
			gnt_oh <= '0;
		end
	end

	assign gnt_o = |gnt_oh;

endmodule

// File: src/wb_ic_decode_err.sv
// Decode-error target
// Answers every strobe with a single-cycle err and zero read data
`include "wb_ic_settings.svh"

module wb_ic_decode_err
	import wb_ic_pkg::*;
(
	input  logic    clk,
	input  logic    rstn,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	logic err_q;

	// Blocking on err_q stops a second answer while the strobe is still held
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= req_i.cyc && req_i.stb && !err_q;
		end
	end

	always_comb begin
		rsp_o = '0;
		rsp_o.err = err_q;
	end

endmodule

// File: src/wb_interconnect_3x2.sv
// Wishbone classic crossbar, three masters to two targets
// Per-master decode, per-target round-robin arbitration, request muxing
// and response steering, with a built-in decode-error target
`include "wb_ic_settings.svh"

module wb_interconnect_3x2
	import wb_ic_pkg::*;
(
	input  logic                               clk,
	input  logic                               rstn,
	input  wb_req_t [`WB_N_MASTERS-1:0]        m_req_i,
	output wb_rsp_t [`WB_N_MASTERS-1:0]        m_rsp_o,
	output wb_req_t [`WB_N_SLAVES-1:0]         s_req_o,
	input  wb_rsp_t [`WB_N_SLAVES-1:0]         s_rsp_i
);

	localparam int N_M = `WB_N_MASTERS;
	// Real targets plus the error target
	localparam int N_T = `WB_N_SLAVES + 1;

	logic [N_T-1:0] mp_req [N_M];
	tgt_id_t        mp_tgt [N_M];
	logic           mp_busy [N_M];
	logic           mp_done [N_M];

	logic [N_M-1:0] arb_req [N_T];
	logic           arb_gnt [N_T];
	logic [1:0]     arb_id [N_T];

	wb_req_t t_req [N_T];
	wb_rsp_t t_rsp [N_T];
	wb_rsp_t err_rsp;

	for (genvar m = 0; m < N_M; m++) begin : g_mport
		wb_ic_master_port mport_i (
			.clk       (clk),
			.rstn      (rstn),
			.req_i     (m_req_i[m]),
			.done_i    (mp_done[m]),
			.tgt_req_o (mp_req[m]),
			.tgt_o     (mp_tgt[m]),
			.busy_o    (mp_busy[m])
		);
		assign mp_done[m] = m_rsp_o[m].ack | m_rsp_o[m].err;
	end

	for (genvar t = 0; t < N_T; t++) begin : g_arb
		// Collect the request bit of every master for this target
		for (genvar m = 0; m < N_M; m++) begin : g_col
			assign arb_req[t][m] = mp_req[m][t];
		end

		wb_ic_arbiter arb_i (
			.clk      (clk),
			.rstn     (rstn),
			.req_i    (arb_req[t]),
			.gnt_o    (arb_gnt[t]),
			.gnt_id_o (arb_id[t])
		);

		// Granted master drives the target, otherwise all zero
		always_comb begin
			t_req[t] = '0;
			if (arb_gnt[t] && arb_req[t][arb_id[t]]) begin
				t_req[t] = m_req_i[arb_id[t]];
			end
		end
	end

	for (genvar s = 0; s < N_T - 1; s++) begin : g_sconn
		assign s_req_o[s] = t_req[s];
		assign t_rsp[s] = s_rsp_i[s];
	end

	wb_ic_decode_err derr_i (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (t_req[TGT_ERR]),
		.rsp_o (err_rsp)
	);
	assign t_rsp[TGT_ERR] = err_rsp;

	// Response goes back only to the master that owns the target
	for (genvar m = 0; m < N_M; m++) begin : g_steer
		always_comb begin
			m_rsp_o[m] = '0;
			if (mp_busy[m] && arb_gnt[mp_tgt[m]] && arb_id[mp_tgt[m]] == 2'(m)) begin
				m_rsp_o[m] = t_rsp[mp_tgt[m]];
			end
		end
	end

endmodule

// File: src/wb_sram_slave.sv
// Single-port SRAM behind a Wishbone classic target port
// Byte-lane writes by sel, registered ack and read data
`include "wb_ic_settings.svh"

module wb_sram_slave
	import wb_ic_pkg::*;
(
	input  logic    clk,
	input  logic    rstn,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	localparam int DW = $bits(req_i.dat_w);
	localparam int NB = DW / 8;
	localparam int IW = $clog2(`WB_SRAM_WORDS);

	logic [DW-1:0] mem [`WB_SRAM_WORDS];
	logic [DW-1:0] rd_q;
	logic          ack_q;
	logic [IW-1:0] idx;
	logic          access;

	// Word index from the byte address
	assign idx = req_i.adr[IW+1:2];
	assign access = req_i.cyc && req_i.stb && !ack_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			rd_q <= mem[idx];
			if (req_i.we) begin
				for (int b = 0; b < NB; b++) begin
					if (req_i.sel[b]) begin
						mem[idx][b*8 +: 8] <= req_i.dat_w[b*8 +: 8];
					end
				end
			end
		end
	end

	assign rsp_o.dat_r = rd_q;
	assign rsp_o.ack = ack_q;
	assign rsp_o.err = 1'b0;

endmodule

// File: src/wb_ic_subsys.sv
// Crossbar subsystem top
// Three external masters reach two SRAM targets through the crossbar
`include "wb_ic_settings.svh"

module wb_ic_subsys
	import wb_ic_pkg::*;
(
	input  logic                         clk,
	input  logic                         rstn,
	input  wb_req_t [`WB_N_MASTERS-1:0]  m_req_i,
	output wb_rsp_t [`WB_N_MASTERS-1:0]  m_rsp_o
);

	wb_req_t [`WB_N_SLAVES-1:0] s_req;
	wb_rsp_t [`WB_N_SLAVES-1:0] s_rsp;

	wb_interconnect_3x2 xbar_i (
		.clk     (clk),
		.rstn    (rstn),
		.m_req_i (m_req_i),
		.m_rsp_o (m_rsp_o),
		.s_req_o (s_req),
		.s_rsp_i (s_rsp)
	);

	wb_sram_slave sram0_i (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (s_req[0]),
		.rsp_o (s_rsp[0])
	);

	wb_sram_slave sram1_i (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (s_req[1]),
		.rsp_o (s_rsp[1])
	);

endmodule

// File: tests/tb_wb_ic_subsys.sv
// Testbench for the Wishbone crossbar subsystem
// Replays transaction groups from the case file on three masters
// and checks responses, latency and round-robin fairness
`include "wb_ic_settings.svh"

module tb_wb_ic_subsys
	import wb_ic_pkg::*;
();

	localparam int MAX_CASES = 64;
	localparam int MAX_LINES = 16;
	localparam int TIMEOUT = 50;
	localparam int NM = `WB_N_MASTERS;

	// One transaction from the case file
	typedef struct packed {
		logic [7:0]  grp;
		logic [1:0]  mst;
		logic        we;
		logic [31:0] adr;
		logic [31:0] dat_w;
		logic [3:0]  sel;
		logic [31:0] exp_rd;
		logic        exp_err;
	} case_t;

	logic               clk;
	logic               rstn;
	wb_req_t [NM-1:0]   m_req;
	wb_rsp_t [NM-1:0]   m_rsp;

	case_t cases [MAX_CASES];
	int    n_cases;
	int    line_idx [NM][MAX_LINES];
	int    n_lines [NM];
	int    done_cnt [NM];
	bit    single_master;
	int    errors;
	int    checks;
	int    tests;

	wb_ic_subsys dut_i (
		.clk     (clk),
		.rstn    (rstn),
		.m_req_i (m_req),
		.m_rsp_o (m_rsp)
	);

	always #10 clk = ~clk;

	task automatic drive_req(input int m, input wb_req_t r);
		case (m)
			0: m_req[0] <= r;
			1: m_req[1] <= r;
			default: m_req[2] <= r;
		endcase
	endtask

	// Runs the lines of one master in order, one classic cycle each
	task automatic run_master(input int m);
		case_t   c;
		wb_rsp_t rsp;
		int      cycles;
		bit      done;
		int      n;
		for (int k = 0; k < n_lines[m]; k++) begin
			c = cases[line_idx[m][k]];
			if (k > 0) begin
				@(posedge clk);
			end
			drive_req(m, {c.adr, c.dat_w, c.sel, c.we, 1'b1, 1'b1});
			cycles = 0;
			done = 1'b0;
			while (!done && cycles < TIMEOUT) begin
				@(posedge clk);
				cycles++;
				rsp = m_rsp[m];
				done = rsp.ack || rsp.err;
			end
			drive_req(m, '0);
			if (!done) begin
				$display("timeout: master %0d saw no ack or err for address %h in %0d cycles",
					m, c.adr, TIMEOUT);
				errors++;
			end else begin
				checks++;
				if (rsp.err !== c.exp_err) begin
					$display("mismatch m_rsp_o[%0d].err: got %h expected %h", m, rsp.err, c.exp_err);
					errors++;
				end
				if (rsp.ack !== !c.exp_err) begin
					$display("mismatch m_rsp_o[%0d].ack: got %h expected %h", m, rsp.ack, !c.exp_err);
					errors++;
				end
				if (!c.we && rsp.dat_r !== c.exp_rd) begin
					$display("mismatch m_rsp_o[%0d].dat_r: got %h expected %h",
						m, rsp.dat_r, c.exp_rd);
					errors++;
				end
				// Ack seen at the sampling edge after the ack cycle
				if (single_master && cycles - 1 != 3) begin
					$display("master %0d access to %h took %0d cycles instead of 3",
						m, c.adr, cycles - 1);
					errors++;
				end
				done_cnt[m]++;
				n = done_cnt[m];
				for (int o = 0; o < NM; o++) begin
					if (o != m && n_lines[o] >= n - 1 && done_cnt[o] < n - 1) begin
						$display("master %0d finished access %0d before master %0d finished %0d",
							m, n, o, n - 1);
						errors++;
					end
				end
			end
		end
	endtask

	initial begin
		int          fd;
		int          rc;
		int          g;
		int          m;
		int          we_v;
		int          er_v;
		logic [31:0] adr;
		logic [31:0] wd;
		logic [31:0] rd;
		logic [3:0]  sel;
		string       line;
		int          max_grp;
		int          err_before;
		int          n_act;
		clk = 1'b0;
		rstn = 1'b0;
		m_req = '0;
		n_cases = 0;
		max_grp = 0;
		errors = 0;
		checks = 0;
		tests = 0;

		fd = $fopen("tests/wb_ic_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open the case file tests/wb_ic_cases.txt");
			errors++;
		end else begin
			while (!$feof(fd) && n_cases < MAX_CASES) begin
				line = "";
				rc = $fgets(line, fd);
				if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin
					rc = $sscanf(line, "%d %d %d %h %h %h %h %d", g, m, we_v, adr, wd, sel, rd, er_v);
					if (rc == 8) begin
						cases[n_cases] = {8'(g), 2'(m), we_v[0], adr, wd, sel, rd, er_v[0]};
						n_cases++;
						if (g > max_grp) begin
							max_grp = g;
						end
					end
				end
			end
			$fclose(fd);
			if (n_cases == 0) begin
				$display("the case file holds no usable lines");
				errors++;
			end
		end

		repeat (8) @(posedge clk);
		rstn <= 1'b1;

		// Nothing may answer while all masters are idle
		err_before = errors;
		for (int i = 0; i < 5; i++) begin
			@(posedge clk);
			for (int j = 0; j < NM; j++) begin
				checks++;
				if (m_rsp[j].ack !== 1'b0 || m_rsp[j].err !== 1'b0) begin
					$display("mismatch m_rsp_o[%0d].ack/err: got %h expected 0",
						j, {m_rsp[j].ack, m_rsp[j].err});
					errors++;
				end
			end
		end
		tests++;
		$display("reset: %s", errors == err_before ? "ok" : "failed");

		for (int grp = 1; grp <= max_grp; grp++) begin
			for (int i = 0; i < NM; i++) begin
				n_lines[i] = 0;
				done_cnt[i] = 0;
			end
			for (int i = 0; i < n_cases; i++) begin
				m = int'(cases[i].mst);
				if (int'(cases[i].grp) == grp && m < NM && n_lines[m] < MAX_LINES) begin
					line_idx[m][n_lines[m]] = i;
					n_lines[m]++;
				end
			end
			n_act = 0;
			for (int i = 0; i < NM; i++) begin
				if (n_lines[i] > 0) begin
					n_act++;
				end
			end
			if (n_act > 0) begin
				single_master = (n_act == 1);
				err_before = errors;
				@(posedge clk);
				fork
					run_master(0);
					run_master(1);
					run_master(2);
				join
				// Idle gap so every grant is released
				repeat (2) @(posedge clk);
				tests++;
				$display("group %0d: %0d masters, %s", grp, n_act,
					errors == err_before ? "ok" : "failed");
			end
		end

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: wb_ic_subsys.f
+incdir+src
src/wb_ic_pkg.sv
src/wb_ic_master_port.sv
src/wb_ic_arbiter.sv
src/wb_ic_decode_err.sv
src/wb_interconnect_3x2.sv
src/wb_sram_slave.sv
src/wb_ic_subsys.sv
tests/tb_wb_ic_subsys.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_wb_ic_subsys
FLIST     = wb_ic_subsys.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/wb_ic_cases.txt
# group master we address write_data sel expected_read_data expected_err
# hex fields: address, write_data, sel, expected_read_data; reads carry zero write data
1 0 1 00000010 11110000 f 00000000 0
1 0 1 00010010 22220000 f 00000000 0
1 0 0 00000010 00000000 f 11110000 0
1 0 0 00010010 00000000 f 22220000 0
2 1 1 00000020 33330000 f 00000000 0
2 1 1 00010020 44440000 f 00000000 0
2 1 0 00000020 00000000 f 33330000 0
2 1 0 00010020 00000000 f 44440000 0
2 2 1 000103fc 66660000 f 00000000 0
2 2 1 000003fc 55550000 f 00000000 0
2 2 0 000103fc 00000000 f 66660000 0
2 2 0 000003fc 00000000 f 55550000 0
3 2 1 00000040 deadbeef f 00000000 0
3 2 1 00000040 0000ab00 2 00000000 0
3 2 1 00000040 cd000000 8 00000000 0
3 2 0 00000040 00000000 f cdadabef 0
4 1 1 00000080 12345678 f 00000000 0
4 1 1 00008000 ffffffff f 00000000 1
4 1 0 00008000 00000000 f 00000000 1
4 1 1 00020000 ffffffff f 00000000 1
4 1 0 00020000 00000000 f 00000000 1
4 1 0 00000080 00000000 f 12345678 0
5 0 0 00000010 00000000 f 11110000 0
5 0 1 00000100 aaaa0000 f 00000000 0
5 1 0 00000020 00000000 f 33330000 0
5 1 0 00000040 00000000 f cdadabef 0
5 2 0 000003fc 00000000 f 55550000 0
5 2 0 00000010 00000000 f 11110000 0
6 0 0 00010010 00000000 f 22220000 0
6 1 0 00000020 00000000 f 33330000 0
6 2 0 00020000 00000000 f 00000000 1
